/* graph_update_params.svh */
// Field widths, buffer depth and almost-full margin of the graph update unit
`ifndef GRAPH_UPDATE_PARAMS_SVH
`define GRAPH_UPDATE_PARAMS_SVH

// Vertex id, edge destination and counter width
`define GU_VERTEX_BITS 32

// Edge data word and inverse out-degree width
`define GU_DATA_BITS 32

// Width of each compute unit id coordinate
`define GU_CU_ID_BITS 8

// Update record buffer
`define GU_FIFO_DEPTH 16

// Free slots left when almost-full rises
`define GU_ALFULL_MARGIN 4

`endif

/* graph_update_pkg.sv */
// Record structs, buffer status and kernel state enum for the graph update unit
`default_nettype none
`include "graph_update_params.svh"

package graph_update_pkg;

	////////////////////////////////////////////////////////////
	// Input records
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`GU_VERTEX_BITS-1:0] id;
		logic [`GU_DATA_BITS-1:0]   inverse_out_degree;
	} vertex_job_payload_t;

	typedef struct packed {
		logic                valid;
		vertex_job_payload_t payload;
	} vertex_job_t;

	typedef struct packed {
		logic [`GU_DATA_BITS-1:0]   data;
		logic [`GU_VERTEX_BITS-1:0] dest;
	} edge_data_payload_t;

	typedef struct packed {
		logic               valid;
		edge_data_payload_t payload;
	} edge_data_t;

	////////////////////////////////////////////////////////////
	// Output records
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`GU_VERTEX_BITS-1:0] index;
		logic [`GU_CU_ID_BITS-1:0]  cu_id_x;
		logic [`GU_CU_ID_BITS-1:0]  cu_id_y;
		logic [`GU_DATA_BITS-1:0]   data_1;
		logic [`GU_VERTEX_BITS-1:0] data_2;
	} edge_update_payload_t;

	typedef struct packed {
		logic                 valid;
		edge_update_payload_t payload;
	} edge_update_t;

	typedef struct packed {
		logic                     valid;
		logic [`GU_DATA_BITS-1:0] tag;
	} write_response_t;

	// Flags of any record buffer, local or external
	typedef struct packed {
		logic full;
		logic alfull;
		logic valid;
		logic empty;
	} buffer_status_t;

	typedef enum logic [1:0] {
		state_idle,
		state_wait_job,
		state_stream_edges
	} kernel_state_e;

endpackage

`default_nettype wire

/* update_fifo.sv */
// Synchronous record buffer with full, almost-full, empty and valid flags
`timescale 1ns/1ps
`default_nettype none
`include "graph_update_params.svh"

module update_fifo import graph_update_pkg::*; #(
	parameter int DEPTH         = `GU_FIFO_DEPTH,
	parameter int ALFULL_MARGIN = `GU_ALFULL_MARGIN
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           push,
	input  edge_update_t   data_in,
	input  logic           pop,
	output edge_update_t   data_out,
	output buffer_status_t status
);

	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	edge_update_payload_t mem [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                push_ok;
	logic                pop_ok;

	// Overflow and underflow requests are ignored
	assign push_ok = push && ~status.full;
	assign pop_ok  = pop && ~status.empty;

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (push_ok) begin
			mem[wr_ptr] <= data_in.payload;
		end
	end

	////////////////////////////////////////////////////////////
	// Head record and flags
	////////////////////////////////////////////////////////////

	// Show-ahead head, valid whenever something is stored
	assign data_out = '{valid: (count != '0), payload: mem[rd_ptr]};

	assign status = '{
		full:   (count == CNT_BITS'(DEPTH)),
		alfull: (count >= CNT_BITS'(DEPTH - ALFULL_MARGIN)),
		valid:  (count != '0),
		empty:  (count == '0)
	};

endmodule

`default_nettype wire

/* update_kernel.sv */
// Update kernel turning the held vertex job and incoming edges into records
`timescale 1ns/1ps
`default_nettype none
`include "graph_update_params.svh"

module update_kernel import graph_update_pkg::*; #(
	parameter logic [`GU_CU_ID_BITS-1:0] CU_ID_X = '0,
	parameter logic [`GU_CU_ID_BITS-1:0] CU_ID_Y = '0
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  vertex_job_t                vertex_job,
	input  edge_data_t                 edge_data,
	input  buffer_status_t             buffer_status,
	output edge_update_t               edge_update,
	output logic                       edge_data_request,
	output logic [`GU_VERTEX_BITS-1:0] edge_count
);

	kernel_state_e              state;
	logic [`GU_VERTEX_BITS-1:0] held_id;
	logic                       take_edge;
	logic                       record_valid;
	edge_update_payload_t       record_payload;

	////////////////////////////////////////////////////////////
	// Job FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= state_idle;
		end else if (!enabled) begin
			state <= state_idle;
		end else begin
			case (state)
				state_idle:         state <= vertex_job.valid ? state_stream_edges : state_wait_job;
				state_wait_job:     if (vertex_job.valid) state <= state_stream_edges;
				state_stream_edges: state <= state_stream_edges;
				default:            state <= state_idle;
			endcase
		end
	end

	// A new job simply replaces the held one
	always_ff @(posedge clock) begin
		if (enabled && vertex_job.valid) begin
			held_id <= vertex_job.payload.id;
		end
	end

	////////////////////////////////////////////////////////////
	// Record build
	////////////////////////////////////////////////////////////

	// Zero data edges are dropped here but still counted below
	assign take_edge = enabled && (state == state_stream_edges) && edge_data.valid &&
		(|edge_data.payload.data) && ~buffer_status.full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			record_valid <= 1'b0;
		end else begin
			record_valid <= take_edge;
		end
	end

	always_ff @(posedge clock) begin
		if (take_edge) begin
			record_payload.index   <= held_id;
			record_payload.cu_id_x <= CU_ID_X;
			record_payload.cu_id_y <= CU_ID_Y;
			record_payload.data_1  <= `GU_DATA_BITS'(1);
			record_payload.data_2  <= edge_data.payload.dest;
		end
	end

	// Valid bit doubles as the buffer push
	assign edge_update = '{valid: record_valid, payload: record_payload};

	////////////////////////////////////////////////////////////
	// Edge request and counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data_request <= 1'b0;
			edge_count        <= '0;
		end else begin
			// Almost-full margin covers records already in flight
			edge_data_request <= enabled && (state == state_stream_edges) &&
				~buffer_status.alfull;
			if (enabled && edge_data.valid) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* write_port.sv */
// Write port requesting the bus, popping records on grant and counting responses
`timescale 1ns/1ps
`default_nettype none
`include "graph_update_params.svh"

module write_port import graph_update_pkg::*; (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  edge_update_t               head,
	input  buffer_status_t             buffer_status,
	input  buffer_status_t             write_buffer_status,
	input  logic                       write_bus_grant,
	input  write_response_t            write_response,
	output logic                       pop,
	output logic                       write_bus_request,
	output edge_update_t               edge_update_out,
	output logic [`GU_VERTEX_BITS-1:0] response_count
);

	logic                 grant_q;
	logic                 out_valid;
	edge_update_payload_t out_payload;

	// Guard against a grant that lands after the last record already left
	assign pop = grant_q && buffer_status.valid;

	////////////////////////////////////////////////////////////
	// Bus request and grant
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q           <= 1'b0;
			write_bus_request <= 1'b0;
			out_valid         <= 1'b0;
		end else begin
			grant_q <= enabled && write_bus_grant && write_bus_request &&
				~write_buffer_status.alfull;
			write_bus_request <= enabled && ~buffer_status.empty &&
				~write_buffer_status.alfull;
			out_valid <= pop;
		end
	end

	// Head is captured on the same edge the buffer drops it
	always_ff @(posedge clock) begin
		if (pop) begin
			out_payload <= head.payload;
		end
	end

	assign edge_update_out = '{valid: out_valid, payload: out_payload};

	////////////////////////////////////////////////////////////
	// Write responses
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_count <= '0;
		end else if (enabled && write_response.valid) begin
			response_count <= response_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* graph_update_cu.sv */
// Compute unit top with reset synchronizer, update kernel, record buffer and write port
`timescale 1ns/1ps
`default_nettype none
`include "graph_update_params.svh"

module graph_update_cu import graph_update_pkg::*; #(
	parameter logic [`GU_CU_ID_BITS-1:0] CU_ID_X = '0,
	parameter logic [`GU_CU_ID_BITS-1:0] CU_ID_Y = '0
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  vertex_job_t                vertex_job,
	input  edge_data_t                 edge_data,
	input  buffer_status_t             write_buffer_status,
	input  logic                       write_bus_grant,
	input  write_response_t            write_response,
	output logic                       edge_data_request,
	output logic                       write_bus_request,
	output edge_update_t               edge_update_out,
	output logic [`GU_VERTEX_BITS-1:0] edge_count,
	output logic [`GU_VERTEX_BITS-1:0] response_count
);

	logic [1:0]     rstn_pipe;
	logic           rstn_int;
	logic           enabled_int;
	edge_update_t   kernel_record;
	edge_update_t   fifo_head;
	buffer_status_t fifo_status;
	logic           fifo_pop;

	////////////////////////////////////////////////////////////
	// Reset and enable
	////////////////////////////////////////////////////////////

	// Assert at once, release two clocks after rstn rises
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rstn_pipe <= 2'b00;
		end else begin
			rstn_pipe <= {rstn_pipe[0], 1'b1};
		end
	end

	assign rstn_int = rstn_pipe[1];

	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			enabled_int <= 1'b0;
		end else begin
			enabled_int <= enabled;
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	update_kernel #(
		.CU_ID_X(CU_ID_X),
		.CU_ID_Y(CU_ID_Y)
	) u_kernel (
		.clock            (clock),
		.rstn             (rstn_int),
		.enabled          (enabled_int),
		.vertex_job       (vertex_job),
		.edge_data        (edge_data),
		.buffer_status    (fifo_status),
		.edge_update      (kernel_record),
		.edge_data_request(edge_data_request),
		.edge_count       (edge_count)
	);

	update_fifo #(
		.DEPTH        (`GU_FIFO_DEPTH),
		.ALFULL_MARGIN(`GU_ALFULL_MARGIN)
	) u_fifo (
		.clock   (clock),
		.rstn    (rstn_int),
		.push    (kernel_record.valid),
		.data_in (kernel_record),
		.pop     (fifo_pop),
		.data_out(fifo_head),
		.status  (fifo_status)
	);

	write_port u_write_port (
		.clock              (clock),
		.rstn               (rstn_int),
		.enabled            (enabled_int),
		.head               (fifo_head),
		.buffer_status      (fifo_status),
		.write_buffer_status(write_buffer_status),
		.write_bus_grant    (write_bus_grant),
		.write_response     (write_response),
		.pop                (fifo_pop),
		.write_bus_request  (write_bus_request),
		.edge_update_out    (edge_update_out),
		.response_count     (response_count)
	);

endmodule

`default_nettype wire

/* tb_graph_update_cu.sv */
// Testbench for the graph update compute unit with reference model, comparer and timeout
`timescale 1ns/1ps
`default_nettype none
`include "graph_update_params.svh"

module tb_graph_update_cu import graph_update_pkg::*; ();

	localparam logic [`GU_CU_ID_BITS-1:0] CU_X = 8'd3;
	localparam logic [`GU_CU_ID_BITS-1:0] CU_Y = 8'd5;
	// Edges offered over the stream, back-pressure, write buffer and disable tests
	localparam int NUM_EDGES   = 55;
	localparam int CYCLE_LIMIT = 40 * NUM_EDGES + 200;

	logic                       clock;
	logic                       rstn;
	logic                       enabled;
	vertex_job_t                vertex_job;
	edge_data_t                 edge_data;
	buffer_status_t             write_buffer_status;
	logic                       write_bus_grant;
	write_response_t            write_response;
	logic                       edge_data_request;
	logic                       write_bus_request;
	edge_update_t               edge_update_out;
	logic [`GU_VERTEX_BITS-1:0] edge_count;
	logic [`GU_VERTEX_BITS-1:0] response_count;

	integer               seed = 14382;
	int                   cycles;
	int                   edges_sent;
	int                   responses_sent;
	string                test_name;
	logic                 no_output;
	logic                 no_request;
	vertex_job_payload_t  current_job;
	edge_update_payload_t expected_q [$];

	graph_update_cu #(
		.CU_ID_X(CU_X),
		.CU_ID_Y(CU_Y)
	) dut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Reference model and reporting
	////////////////////////////////////////////////////////////

	// Valid low when the edge carries zero data and is dropped
	function automatic edge_update_t reference_record(input vertex_job_payload_t job,
			input edge_data_payload_t edge_in);
		edge_update_t rec;
		rec.valid           = (edge_in.data != '0);
		rec.payload.index   = job.id;
		rec.payload.cu_id_x = CU_X;
		rec.payload.cu_id_y = CU_Y;
		rec.payload.data_1  = 32'd1;
		rec.payload.data_2  = edge_in.dest;
		return rec;
	endfunction

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_count(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else
			stop_on_error($sformatf("MISMATCH %s %s: expected %0d, actual %0d",
				test_name, what, expected, actual));
	endtask

	////////////////////////////////////////////////////////////
	// Comparer and timeout
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		edge_update_payload_t expected;
		if (no_request) begin
			assert (!write_bus_request) else
				stop_on_error($sformatf("Write bus request raised during %s", test_name));
		end
		if (no_output) begin
			assert (!edge_update_out.valid) else
				stop_on_error($sformatf("Record written out during %s", test_name));
		end
		if (edge_update_out.valid) begin
			assert (expected_q.size() != 0) else
				stop_on_error($sformatf("Record written out in %s with none pending", test_name));
			expected = expected_q.pop_front();
			assert (edge_update_out.payload == expected) else
				stop_on_error($sformatf("MISMATCH %s: expected %h, actual %h",
					test_name, expected, edge_update_out.payload));
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			stop_on_error($sformatf("Timeout: run did not end within %0d cycles", CYCLE_LIMIT));
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic start_job(input logic [31:0] id);
		@(posedge clock);
		current_job = '{id: id, inverse_out_degree: $random(seed)};
		vertex_job <= '{valid: 1'b1, payload: current_job};
		@(posedge clock);
		vertex_job.valid <= 1'b0;
	endtask

	// Offers an edge whenever the request was high, optionally stops once it falls
	task automatic send_edges(input int n, input bit nonzero_only, input bit stop_on_stall,
			output int sent);
		edge_data_payload_t e;
		edge_update_t       rec;
		bit                 stalled;
		sent    = 0;
		stalled = 1'b0;
		while (sent < n && !stalled) begin
			@(posedge clock);
			if (edge_data_request) begin
				e.dest = $random(seed);
				e.data = ({$random(seed)} % 3 == 0) ? '0 : $random(seed);
				if (nonzero_only) begin
					e.data = e.data | 32'd1;
				end
				edge_data <= '{valid: 1'b1, payload: e};
				rec = reference_record(current_job, e);
				if (rec.valid) begin
					expected_q.push_back(rec.payload);
				end
				sent++;
			end else begin
				edge_data.valid <= 1'b0;
				stalled = stop_on_stall && (sent > 0);
			end
		end
		@(posedge clock);
		edge_data.valid <= 1'b0;
		edges_sent += sent;
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
	endtask

	initial begin
		int          sent;
		logic [31:0] r;
		rstn                <= 1'b0;
		enabled             <= 1'b0;
		vertex_job          <= '0;
		edge_data           <= '0;
		write_buffer_status <= '{full: 1'b0, alfull: 1'b0, valid: 1'b0, empty: 1'b1};
		write_bus_grant     <= 1'b0;
		write_response      <= '0;
		no_output           <= 1'b0;
		no_request          <= 1'b0;

		test_name = "reset";
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
		repeat (4) @(posedge clock);
		assert (!edge_data_request && !write_bus_request && !edge_update_out.valid) else
			stop_on_error("A control output is high after reset");
		check_count("edge_count", 0, edge_count);
		check_count("response_count", 0, response_count);

		// Free running grant, a third of the edges carry zero data
		test_name = "stream";
		enabled         <= 1'b1;
		write_bus_grant <= 1'b1;
		repeat (4) @(posedge clock);
		start_job(32'h0000_1234);
		send_edges(20, 1'b0, 1'b0, sent);
		wait_drain();
		check_count("edge_count", edges_sent, edge_count);

		test_name = "backpressure";
		write_bus_grant <= 1'b0;
		no_output       <= 1'b1;
		start_job(32'h0000_5678);
		send_edges(20, 1'b1, 1'b1, sent);
		repeat (10) @(posedge clock);
		assert (sent < 20 && !edge_data_request) else
			stop_on_error("Edge request stayed high with the write bus withheld");
		write_bus_grant <= 1'b1;
		no_output       <= 1'b0;
		send_edges(20 - sent, 1'b1, 1'b0, sent);
		wait_drain();
		check_count("edge_count", edges_sent, edge_count);

		test_name = "write_buffer_almost_full";
		write_buffer_status <= '{full: 1'b0, alfull: 1'b1, valid: 1'b1, empty: 1'b0};
		repeat (2) @(posedge clock);
		no_request <= 1'b1;
		no_output  <= 1'b1;
		send_edges(12, 1'b0, 1'b1, sent);
		repeat (20) @(posedge clock);
		no_request          <= 1'b0;
		no_output           <= 1'b0;
		write_buffer_status <= '{full: 1'b0, alfull: 1'b0, valid: 1'b0, empty: 1'b1};
		wait_drain();
		check_count("edge_count", edges_sent, edge_count);

		test_name = "responses";
		repeat (40) begin
			@(posedge clock);
			r = $random(seed);
			write_response <= '{valid: r[0], tag: r};
			if (r[0]) begin
				responses_sent++;
			end
		end
		@(posedge clock);
		write_response.valid <= 1'b0;
		repeat (2) @(posedge clock);
		check_count("response_count", responses_sent, response_count);

		// Records wait in the buffer, counters hold and requests stay low
		test_name = "disabled";
		write_bus_grant <= 1'b0;
		send_edges(3, 1'b1, 1'b0, sent);
		repeat (4) @(posedge clock);
		enabled <= 1'b0;
		repeat (4) @(posedge clock);
		no_request      <= 1'b1;
		no_output       <= 1'b1;
		write_bus_grant <= 1'b1;
		repeat (20) begin
			@(posedge clock);
			r = $random(seed);
			write_response <= '{valid: r[0], tag: r};
			edge_data      <= '{valid: r[1], payload: '{data: r, dest: r}};
			assert (!edge_data_request) else
				stop_on_error("Edge request high while the unit is disabled");
		end
		@(posedge clock);
		write_response.valid <= 1'b0;
		edge_data.valid      <= 1'b0;
		repeat (3) @(posedge clock);
		check_count("response_count", responses_sent, response_count);
		check_count("edge_count", edges_sent, edge_count);
		no_request <= 1'b0;
		no_output  <= 1'b0;
		enabled    <= 1'b1;
		wait_drain();

		if (expected_q.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stop_on_error("Expected records still pending at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* graph_update_cu.f */
+incdir+.
graph_update_pkg.sv
update_fifo.sv
update_kernel.sv
write_port.sv
graph_update_cu.sv
tb_graph_update_cu.sv

/* Makefile */
# Verilator lint, simulation and clean for the graph update compute unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module graph_update_cu -f graph_update_cu.f

obj_dir/Vtb_graph_update_cu: graph_update_cu.f graph_update_params.svh *.sv
	verilator --binary --timing --assert --top-module tb_graph_update_cu -f graph_update_cu.f

sim: obj_dir/Vtb_graph_update_cu
	./obj_dir/Vtb_graph_update_cu > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" sim.log; then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log
